// ==== files.f ====
hw/sched_pkg.sv
hw/queue_store.sv
hw/prio_scheduler.sv
hw/egress_shaper.sv
hw/packet_scheduler_top.sv
tb/packet_scheduler_sva.sv
tb/packet_scheduler_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the packet scheduler testbench with Verilator

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module packet_scheduler_tb -o packet_scheduler_sim \
    && ./obj_dir/packet_scheduler_sim +verilator+error+limit+100 > sim.log 2>&1 \
    || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0

// ==== tb/packet_scheduler_tb.sv ====
////////////////////////////////////////////////////////////
// Testbench for the egress packet scheduler
////////////////////////////////////////////////////////////

module packet_scheduler_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import sched_pkg::*;

    localparam int NUM_PORTS       = 4;
    localparam int QUEUES_PER_PORT = 4;
    localparam int QUEUE_DEPTH     = 8;
    localparam int NUM_QUEUES      = NUM_PORTS * QUEUES_PER_PORT;
    localparam int QID_W           = $clog2(NUM_QUEUES);
    localparam int PORT_W          = $clog2(NUM_PORTS);
    localparam int NUM_ROUNDS      = 8;
    localparam int BURST_LEN       = 24;
    localparam int DRAIN_LIMIT     = 60000;

    logic                 core_clk_ifc;
    logic                 rst_n;
    logic                 enq_valid;
    logic [QID_W-1:0]     enq_queue;
    logic [BLEN_W-1:0]    enq_blen;
    logic                 enq_drop;
    logic                 egr_valid;
    logic [PORT_W-1:0]    egr_port;
    logic [QID_W-1:0]     egr_queue;
    logic [WBYTES_W-1:0]  egr_bytes;
    logic                 egr_last;
    logic [31:0]          lcg_state = 32'h0879b10d;

    packet_scheduler_top #(
        .NUM_PORTS       (NUM_PORTS),
        .QUEUES_PER_PORT (QUEUES_PER_PORT),
        .QUEUE_DEPTH     (QUEUE_DEPTH)
    ) packet_scheduler_top_i (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .enq_valid    (enq_valid),
        .enq_queue    (enq_queue),
        .enq_blen     (enq_blen),
        .enq_drop     (enq_drop),
        .egr_valid    (egr_valid),
        .egr_port     (egr_port),
        .egr_queue    (egr_queue),
        .egr_bytes    (egr_bytes),
        .egr_last     (egr_last)
    );

    bind packet_scheduler_top packet_scheduler_sva #(
        .NUM_PORTS       (NUM_PORTS),
        .QUEUES_PER_PORT (QUEUES_PER_PORT),
        .QUEUE_DEPTH     (QUEUE_DEPTH)
    ) sva_i (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .enq_valid    (enq_valid),
        .enq_queue    (enq_queue),
        .enq_blen     (enq_blen),
        .enq_drop     (enq_drop),
        .egr_valid    (egr_valid),
        .egr_port     (egr_port),
        .egr_queue    (egr_queue),
        .egr_bytes    (egr_bytes),
        .egr_last     (egr_last)
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #4 core_clk_ifc = ~core_clk_ifc;
    end

    function automatic logic [31:0] next_random(input logic [31:0] cur);
        return cur * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic push_packet(input int qid, input int blen);
        @(posedge core_clk_ifc);
        enq_valid <= 1'b1;
        enq_queue <= QID_W'(qid);
        enq_blen  <= BLEN_W'(blen);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge core_clk_ifc);
            enq_valid <= 1'b0;
        end
    endtask

    // Stop at the first assertion failure of the bound checker
    always @(negedge core_clk_ifc) begin
        if (packet_scheduler_top_i.sva_i.failed) begin
            $display("Simulation finished: FAIL");
            $fatal(1, "stopped at the first assertion failure");
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        int          qid;
        int          blen;
        int          drain_cnt;
        logic [31:0] rnd;
        rst_n     = 1'b0;
        enq_valid = 1'b0;
        enq_queue = '0;
        enq_blen  = '0;
        rnd       = '0;
        repeat (16) @(posedge core_clk_ifc);
        rst_n <= 1'b1;

        for (int r = 0; r < NUM_ROUNDS; r++) begin
            for (int i = 0; i < BURST_LEN; i++) begin
                lcg_state = next_random(lcg_state);
                rnd       = lcg_state;
                // Odd rounds hammer two queues so they fill up and drop
                if (r % 2 == 1) begin
                    qid = (r * 5 + int'(rnd[28])) % NUM_QUEUES;
                end else begin
                    qid = int'(rnd[31:28]) % NUM_QUEUES;
                end
                // Whole-word lengths now and then
                if (rnd[27:25] == 3'd0) begin
                    blen = DATA_BYTES * (1 + int'(rnd[22:8]) % (MTU_BYTES / DATA_BYTES));
                end else begin
                    blen = MIN_BYTES + int'(rnd[22:8]) % (MTU_BYTES - MIN_BYTES + 1);
                end
                if (rnd[24:23] == 2'd0) begin
                    idle_cycles(1);
                end
                push_packet(qid, blen);
            end
            idle_cycles(int'(rnd[31:24]) * 4 + 1);
        end

        // Drain everything that was accepted
        drain_cnt = 0;
        while (!(packet_scheduler_top_i.sva_i.model_empty && !egr_valid) &&
               (drain_cnt < DRAIN_LIMIT)) begin
            @(negedge core_clk_ifc);
            drain_cnt++;
        end
        if (drain_cnt >= DRAIN_LIMIT) begin
            $display("Timeout: accepted packets did not leave within %0d cycles", DRAIN_LIMIT);
            $display("Simulation finished: FAIL");
            $fatal(1, "drain timeout");
        end

        repeat (4) @(negedge core_clk_ifc);
        if (packet_scheduler_top_i.sva_i.failed) begin
            $display("Simulation finished: FAIL");
            $fatal(1, "assertion failure before the end of the run");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// ==== tb/packet_scheduler_sva.sv ====
////////////////////////////////////////////////////////////
// Bound checker for the packet scheduler
// Models the length queues from the top-level ports
////////////////////////////////////////////////////////////

module packet_scheduler_sva #(
    parameter int  NUM_PORTS       = 4,
    parameter int  QUEUES_PER_PORT = 4,
    parameter int  QUEUE_DEPTH     = 8,
    localparam int NUM_QUEUES      = NUM_PORTS * QUEUES_PER_PORT,
    localparam int QID_W           = $clog2(NUM_QUEUES),
    localparam int PORT_W          = $clog2(NUM_PORTS)
) (
    input logic                           core_clk_ifc,
    input logic                           rst_n,
    input logic                           enq_valid,
    input logic [QID_W-1:0]               enq_queue,
    input logic [sched_pkg::BLEN_W-1:0]   enq_blen,
    input logic                           enq_drop,
    input logic                           egr_valid,
    input logic [PORT_W-1:0]              egr_port,
    input logic [QID_W-1:0]               egr_queue,
    input logic [sched_pkg::WBYTES_W-1:0] egr_bytes,
    input logic                           egr_last
);

    timeunit 1ns;
    timeprecision 100ps;

    import sched_pkg::*;

    localparam int PRIO_W = $clog2(QUEUES_PER_PORT);

    // Accepted lengths per queue, oldest at the read index
    logic [BLEN_W-1:0] mdl_len [NUM_QUEUES][QUEUE_DEPTH];
    int                mdl_wr  [NUM_QUEUES];
    int                mdl_rd  [NUM_QUEUES];
    int                mdl_cnt [NUM_QUEUES];
    logic              exp_drop;

    // Packet in progress on the egress bus
    logic                  in_pkt;
    int                    pkt_sum;
    logic [PORT_W-1:0]     prev_port;
    logic [QID_W-1:0]      prev_queue;
    logic [NUM_QUEUES-1:0] prev_busy;

    // Packet starts per port, for the shaper spacing
    int                   cyc;
    int                   last_start [NUM_PORTS];
    int                   last_len   [NUM_PORTS];
    logic [NUM_PORTS-1:0] started;

    logic first_word;
    logic higher_busy;
    logic gap_ok;
    logic model_empty;
    int   cur_sum;
    int   head_len;
    int   head_cnt;
    int   min_gap;
    int   start_gap;
    int   exp_port;
    bit   failed = 1'b0;

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk_ifc) begin
        logic push_q;
        logic pop_q;
        if (!rst_n) begin
            for (int q = 0; q < NUM_QUEUES; q++) begin
                mdl_wr[q]  <= 0;
                mdl_rd[q]  <= 0;
                mdl_cnt[q] <= 0;
            end
            exp_drop <= 1'b0;
        end else begin
            // Full is judged on the count before this edge
            exp_drop <= enq_valid && (mdl_cnt[enq_queue] == QUEUE_DEPTH);
            for (int q = 0; q < NUM_QUEUES; q++) begin
                push_q = enq_valid && (int'(enq_queue) == q) && (mdl_cnt[q] < QUEUE_DEPTH);
                pop_q  = egr_last && (int'(egr_queue) == q);
                if (push_q) begin
                    mdl_len[q][mdl_wr[q]] <= enq_blen;
                    mdl_wr[q]             <= (mdl_wr[q] + 1) % QUEUE_DEPTH;
                end
                if (pop_q) begin
                    mdl_rd[q] <= (mdl_rd[q] + 1) % QUEUE_DEPTH;
                end
                mdl_cnt[q] <= mdl_cnt[q] + int'(push_q) - int'(pop_q);
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            in_pkt    <= 1'b0;
            pkt_sum   <= 0;
            cyc       <= 0;
            started   <= '0;
            prev_busy <= '0;
        end else begin
            cyc <= cyc + 1;
            for (int q = 0; q < NUM_QUEUES; q++) begin
                prev_busy[q] <= (mdl_cnt[q] != 0);
            end
            if (egr_valid) begin
                in_pkt     <= !egr_last;
                pkt_sum    <= cur_sum;
                prev_port  <= egr_port;
                prev_queue <= egr_queue;
            end
            if (first_word) begin
                started[egr_port]    <= 1'b1;
                last_start[egr_port] <= cyc;
                last_len[egr_port]   <= head_len;
            end
        end
    end

    always_comb begin
        first_word = egr_valid && !in_pkt;
        cur_sum    = (in_pkt ? pkt_sum : 0) + int'(egr_bytes);
        head_len   = int'(mdl_len[egr_queue][mdl_rd[egr_queue]]);
        head_cnt   = mdl_cnt[egr_queue];
        // Port number sits above the priority bits of the queue index
        exp_port   = int'(egr_queue) / QUEUES_PER_PORT;
        // Shortest spacing the drain rate allows after the previous packet
        min_gap    = (last_len[egr_port] + ETH_OVERHEAD) / SHAPER_RATE - 1;
        start_gap  = cyc - last_start[egr_port];
        gap_ok     = !started[egr_port] || (start_gap >= min_gap);
        higher_busy = 1'b0;
        for (int q = 0; q < QUEUES_PER_PORT; q++) begin
            if ((q > int'(egr_queue[PRIO_W-1:0])) &&
                prev_busy[int'(egr_port) * QUEUES_PER_PORT + q]) begin
                higher_busy = 1'b1;
            end
        end
        model_empty = 1'b1;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            if (mdl_cnt[q] != 0) begin
                model_empty = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////////////////////////

    a_reset_quiet: assert property (@(posedge core_clk_ifc)
        !rst_n |=> !egr_valid && !egr_last && !enq_drop)
    else begin
        $error("Error t=%0t egr_valid/egr_last/enq_drop expected 0/0/0 got %b/%b/%b",
               $time, $sampled(egr_valid), $sampled(egr_last), $sampled(enq_drop));
        failed = 1'b1;
    end

    a_drop: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        enq_drop == exp_drop)
    else begin
        $error("Error t=%0t enq_drop expected %b got %b",
               $time, $sampled(exp_drop), $sampled(enq_drop));
        failed = 1'b1;
    end

    a_port_id: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        egr_valid |-> int'(egr_port) == exp_port)
    else begin
        $error("Error t=%0t egr_port expected %0d got %0d",
               $time, $sampled(exp_port), $sampled(egr_port));
        failed = 1'b1;
    end

    a_full_word: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        egr_valid && !egr_last |-> int'(egr_bytes) == DATA_BYTES)
    else begin
        $error("Error t=%0t egr_bytes expected %0d got %0d",
               $time, DATA_BYTES, $sampled(egr_bytes));
        failed = 1'b1;
    end

    a_last_word: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        egr_last |-> egr_bytes >= 1 && int'(egr_bytes) <= DATA_BYTES)
    else begin
        $error("Error t=%0t egr_bytes expected 1 to %0d got %0d",
               $time, DATA_BYTES, $sampled(egr_bytes));
        failed = 1'b1;
    end

    a_packet_len: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        egr_last |-> head_cnt > 0 && cur_sum == head_len)
    else begin
        $error("Error t=%0t packet bytes of queue %0d expected %0d got %0d (queued %0d)",
               $time, $sampled(egr_queue), $sampled(head_len), $sampled(cur_sum),
               $sampled(head_cnt));
        failed = 1'b1;
    end

    a_no_gap: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        in_pkt |-> egr_valid && egr_port == prev_port && egr_queue == prev_queue)
    else begin
        $error("Error t=%0t egr_valid/egr_port/egr_queue expected 1/%0d/%0d got %b/%0d/%0d",
               $time, $sampled(prev_port), $sampled(prev_queue), $sampled(egr_valid),
               $sampled(egr_port), $sampled(egr_queue));
        failed = 1'b1;
    end

    a_priority: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        first_word |-> !higher_busy)
    else begin
        $error("Error t=%0t egr_queue %0d started while a higher queue of port %0d held data",
               $time, $sampled(egr_queue), $sampled(egr_port));
        failed = 1'b1;
    end

    a_shaping: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        first_word |-> gap_ok)
    else begin
        $error("Error t=%0t start spacing on port %0d expected >= %0d got %0d",
               $time, $sampled(egr_port), $sampled(min_gap), $sampled(start_gap));
        failed = 1'b1;
    end

endmodule

// ==== hw/packet_scheduler_top.sv ====
////////////////////////////////////////////////////////////
// Egress packet scheduler, queues to shaped word stream
////////////////////////////////////////////////////////////

module packet_scheduler_top #(
    parameter int  NUM_PORTS       = 4,
    parameter int  QUEUES_PER_PORT = 4,
    parameter int  QUEUE_DEPTH     = 8,
    localparam int NUM_QUEUES      = NUM_PORTS * QUEUES_PER_PORT,
    localparam int QID_W           = $clog2(NUM_QUEUES),
    localparam int PORT_W          = $clog2(NUM_PORTS)
) (
    input  logic                           core_clk_ifc,
    input  logic                           rst_n,
    input  logic                           enq_valid,
    input  logic [QID_W-1:0]               enq_queue,
    input  logic [sched_pkg::BLEN_W-1:0]   enq_blen,
    output logic                           enq_drop,
    output logic                           egr_valid,
    output logic [PORT_W-1:0]              egr_port,
    output logic [QID_W-1:0]               egr_queue,
    output logic [sched_pkg::WBYTES_W-1:0] egr_bytes,
    output logic                           egr_last
);

    import sched_pkg::*;

    logic [NUM_QUEUES-1:0] queue_empty;
    logic [BLEN_W-1:0]     head_blen;
    logic [QID_W-1:0]      rd_queue;
    logic                  pop;
    logic [QID_W-1:0]      pop_queue;
    logic [NUM_PORTS-1:0]  port_ready;

    ////////////////////////////////////////////////////////////
    // Input side
    ////////////////////////////////////////////////////////////

    queue_store #(
        .NUM_PORTS       (NUM_PORTS),
        .QUEUES_PER_PORT (QUEUES_PER_PORT),
        .QUEUE_DEPTH     (QUEUE_DEPTH)
    ) queue_store_i (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .enq_valid    (enq_valid),
        .enq_queue    (enq_queue),
        .enq_blen     (enq_blen),
        .pop          (pop),
        .pop_queue    (pop_queue),
        .rd_queue     (rd_queue),
        .enq_drop     (enq_drop),
        .queue_empty  (queue_empty),
        .head_blen    (head_blen)
    );

    ////////////////////////////////////////////////////////////
    // Scheduler and output shaper
    ////////////////////////////////////////////////////////////

    prio_scheduler #(
        .NUM_PORTS       (NUM_PORTS),
        .QUEUES_PER_PORT (QUEUES_PER_PORT)
    ) prio_scheduler_i (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .queue_empty  (queue_empty),
        .head_blen    (head_blen),
        .port_ready   (port_ready),
        .rd_queue     (rd_queue),
        .pop          (pop),
        .pop_queue    (pop_queue),
        .egr_valid    (egr_valid),
        .egr_port     (egr_port),
        .egr_queue    (egr_queue),
        .egr_bytes    (egr_bytes),
        .egr_last     (egr_last)
    );

    // Shaper sees the same words that leave the block
    egress_shaper #(
        .NUM_PORTS (NUM_PORTS)
    ) egress_shaper_i (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .word_valid   (egr_valid),
        .word_port    (egr_port),
        .word_bytes   (egr_bytes),
        .word_last    (egr_last),
        .port_ready   (port_ready)
    );

endmodule

// ==== hw/egress_shaper.sv ====
////////////////////////////////////////////////////////////
// Per-port byte charge shaper, ready while the charge is negative
////////////////////////////////////////////////////////////

module egress_shaper #(
    parameter int  NUM_PORTS = 4,
    localparam int PORT_W    = $clog2(NUM_PORTS)
) (
    input  logic                           core_clk_ifc,
    input  logic                           rst_n,
    input  logic                           word_valid,
    input  logic [PORT_W-1:0]              word_port,
    input  logic [sched_pkg::WBYTES_W-1:0] word_bytes,
    input  logic                           word_last,
    output logic [NUM_PORTS-1:0]           port_ready
);

    import sched_pkg::*;

    localparam logic signed [CHARGE_W-1:0] OVERHEAD_C = CHARGE_W'(ETH_OVERHEAD);
    localparam logic signed [CHARGE_W-1:0] RATE_C     = CHARGE_W'(SHAPER_RATE);

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port

        logic signed [CHARGE_W-1:0] charge;
        logic signed [CHARGE_W-1:0] charge_add;
        logic signed [CHARGE_W-1:0] charge_sub;

        // Word bytes, plus the per-packet overhead on the last word
        always_comb begin
            charge_add = '0;
            if (word_valid && (word_port == PORT_W'(p))) begin
                charge_add = CHARGE_W'(word_bytes);
                if (word_last) begin
                    charge_add = charge_add + OVERHEAD_C;
                end
            end
        end

        // Drain only while there is charge left
        assign charge_sub = charge[CHARGE_W-1] ? '0 : RATE_C;

        always_ff @(posedge core_clk_ifc) begin
            if (!rst_n) begin
                charge <= '1;
            end else begin
                charge <= charge + charge_add - charge_sub;
            end
        end

        // Sign bit set means negative charge
        assign port_ready[p] = charge[CHARGE_W-1];
    end

endmodule

// ==== hw/prio_scheduler.sv ====
////////////////////////////////////////////////////////////
// Round robin across ready ports, strict priority within a port
// Cuts the chosen packet into bus words
////////////////////////////////////////////////////////////

module prio_scheduler #(
    parameter int  NUM_PORTS       = 4,
    parameter int  QUEUES_PER_PORT = 4,
    localparam int NUM_QUEUES      = NUM_PORTS * QUEUES_PER_PORT,
    localparam int QID_W           = $clog2(NUM_QUEUES),
    localparam int PORT_W          = $clog2(NUM_PORTS)
) (
    input  logic                           core_clk_ifc,
    input  logic                           rst_n,
    input  logic [NUM_QUEUES-1:0]          queue_empty,
    input  logic [sched_pkg::BLEN_W-1:0]   head_blen,
    input  logic [NUM_PORTS-1:0]           port_ready,
    output logic [QID_W-1:0]               rd_queue,
    output logic                           pop,
    output logic [QID_W-1:0]               pop_queue,
    output logic                           egr_valid,
    output logic [PORT_W-1:0]              egr_port,
    output logic [QID_W-1:0]               egr_queue,
    output logic [sched_pkg::WBYTES_W-1:0] egr_bytes,
    output logic                           egr_last
);

    import sched_pkg::*;

    localparam int PRIO_W = $clog2(QUEUES_PER_PORT);
    localparam logic [BLEN_W-1:0]   WORD_BLEN  = BLEN_W'(DATA_BYTES);
    localparam logic [WBYTES_W-1:0] WORD_BYTES = WBYTES_W'(DATA_BYTES);

    sched_state_e state;

    logic [PORT_W-1:0]    last_port;
    logic [NUM_PORTS-1:0] port_eligible;
    logic                 found;
    logic [PORT_W-1:0]    sel_port;
    logic [PRIO_W-1:0]    sel_prio;
    logic [QID_W-1:0]     sel_queue;
    logic                 grant;

    // Packet in flight
    logic [QID_W-1:0]  cur_queue;
    logic [BLEN_W-1:0] remaining;
    logic              final_word;

    ////////////////////////////////////////////////////////////
    // Port and queue selection
    ////////////////////////////////////////////////////////////

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_elig
        assign port_eligible[p] = port_ready[p] &&
                                  !(&queue_empty[p*QUEUES_PER_PORT +: QUEUES_PER_PORT]);
    end

    // Scan starts one past the last served port
    always_comb begin
        found    = 1'b0;
        sel_port = last_port;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            if (!found && port_eligible[(int'(last_port) + i) % NUM_PORTS]) begin
                found    = 1'b1;
                sel_port = PORT_W'((int'(last_port) + i) % NUM_PORTS);
            end
        end
    end

    // Highest index wins, so the last non-empty hit is kept
    always_comb begin
        sel_prio = '0;
        for (int q = 0; q < QUEUES_PER_PORT; q++) begin
            if (!queue_empty[int'(sel_port) * QUEUES_PER_PORT + q]) begin
                sel_prio = PRIO_W'(q);
            end
        end
    end

    assign sel_queue = {sel_port, sel_prio};
    assign rd_queue  = sel_queue;
    assign grant     = (state == st_idle) && found;

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            state     <= st_idle;
            last_port <= PORT_W'(NUM_PORTS - 1);
        end else begin
            case (state)
                st_idle: begin
                    if (found) begin
                        state     <= st_send;
                        last_port <= sel_port;
                    end
                end
                st_send: begin
                    if (final_word) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Segmentation
    ////////////////////////////////////////////////////////////

    // Byte countdown, loaded from the head length at grant
    always_ff @(posedge core_clk_ifc) begin
        if (grant) begin
            cur_queue <= sel_queue;
            remaining <= head_blen;
        end else if ((state == st_send) && !final_word) begin
            remaining <= remaining - WORD_BLEN;
        end
    end

    // Remainder of 1 to DATA_BYTES goes out on the last word
    assign final_word = (remaining <= WORD_BLEN);

    assign egr_valid = (state == st_send);
    assign egr_last  = egr_valid && final_word;
    assign egr_bytes = final_word ? remaining[WBYTES_W-1:0] : WORD_BYTES;
    assign egr_queue = cur_queue;
    assign egr_port  = cur_queue[QID_W-1 -: PORT_W];

    // Queue entry leaves with its last word
    assign pop       = egr_last;
    assign pop_queue = cur_queue;

endmodule

// ==== hw/queue_store.sv ====
////////////////////////////////////////////////////////////
// Packet length queues, one circular FIFO per queue
// Drops enqueues to full queues, pops on scheduler request
////////////////////////////////////////////////////////////

module queue_store #(
    parameter int  NUM_PORTS       = 4,
    parameter int  QUEUES_PER_PORT = 4,
    parameter int  QUEUE_DEPTH     = 8,
    localparam int NUM_QUEUES      = NUM_PORTS * QUEUES_PER_PORT,
    localparam int QID_W           = $clog2(NUM_QUEUES)
) (
    input  logic                         core_clk_ifc,
    input  logic                         rst_n,
    input  logic                         enq_valid,
    input  logic [QID_W-1:0]             enq_queue,
    input  logic [sched_pkg::BLEN_W-1:0] enq_blen,
    input  logic                         pop,
    input  logic [QID_W-1:0]             pop_queue,
    input  logic [QID_W-1:0]             rd_queue,
    output logic                         enq_drop,
    output logic [NUM_QUEUES-1:0]        queue_empty,
    output logic [sched_pkg::BLEN_W-1:0] head_blen
);

    import sched_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(QUEUE_DEPTH);

    // Length storage, indexed by queue then slot
    logic [BLEN_W-1:0] len_mem [NUM_QUEUES][QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr [NUM_QUEUES];
    logic [PTR_W-1:0] rd_ptr [NUM_QUEUES];
    logic [CNT_W-1:0] fill   [NUM_QUEUES];

    logic                  enq_full;
    logic                  enq_accept;
    logic [NUM_QUEUES-1:0] push_hit;
    logic [NUM_QUEUES-1:0] pop_hit;

    ////////////////////////////////////////////////////////////
    // Accept or drop
    ////////////////////////////////////////////////////////////

    // Fill count before this edge decides, a same-cycle pop does not make room
    assign enq_full   = (fill[enq_queue] == FULL_CNT);
    assign enq_accept = enq_valid && !enq_full;

    always_comb begin
        for (int q = 0; q < NUM_QUEUES; q++) begin
            push_hit[q] = enq_accept && (enq_queue == QID_W'(q));
            pop_hit[q]  = pop && (pop_queue == QID_W'(q)) && (fill[q] != '0);
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            enq_drop <= 1'b0;
        end else begin
            enq_drop <= enq_valid && enq_full;
        end
    end

    ////////////////////////////////////////////////////////////
    // FIFO storage and pointers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk_ifc) begin
        if (enq_accept) begin
            len_mem[enq_queue][wr_ptr[enq_queue]] <= enq_blen;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            for (int q = 0; q < NUM_QUEUES; q++) begin
                wr_ptr[q] <= '0;
                rd_ptr[q] <= '0;
                fill[q]   <= '0;
            end
        end else begin
            for (int q = 0; q < NUM_QUEUES; q++) begin
                if (push_hit[q]) begin
                    wr_ptr[q] <= wr_ptr[q] + 1'b1;
                end
                if (pop_hit[q]) begin
                    rd_ptr[q] <= rd_ptr[q] + 1'b1;
                end
                if (push_hit[q] && !pop_hit[q]) begin
                    fill[q] <= fill[q] + 1'b1;
                end else if (!push_hit[q] && pop_hit[q]) begin
                    fill[q] <= fill[q] - 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Status to the scheduler
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int q = 0; q < NUM_QUEUES; q++) begin
            queue_empty[q] = (fill[q] == '0);
        end
    end

    // Oldest length of the queue the scheduler is looking at
    assign head_blen = len_mem[rd_queue][rd_ptr[rd_queue]];

endmodule

// ==== hw/sched_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared constants and types for the egress packet scheduler
////////////////////////////////////////////////////////////

package sched_pkg;

    ////////////////////////////////////////////////////////////
    // Bus and packet sizes
    ////////////////////////////////////////////////////////////

    // Bytes per egress bus word
    parameter int DATA_BYTES = 64;

    // Packet length range
    parameter int MTU_BYTES = 1500;
    parameter int MIN_BYTES = 64;

    // Length field wide enough for MTU_BYTES
    parameter int BLEN_W = $clog2(MTU_BYTES + 1);

    // Word byte count, 0 up to DATA_BYTES inclusive
    parameter int WBYTES_W = $clog2(DATA_BYTES + 1);

    ////////////////////////////////////////////////////////////
    // Shaper settings
    ////////////////////////////////////////////////////////////

    // Preamble, SFD and inter-frame gap, charged once per packet
    parameter int ETH_OVERHEAD = 20;

    // Drain per core clock cycle, in bytes
    parameter int SHAPER_RATE = 8;

    // Signed accumulator width, holds well over one MTU of charge
    parameter int CHARGE_W = 16;

    ////////////////////////////////////////////////////////////
    // Scheduler FSM
    ////////////////////////////////////////////////////////////

    typedef enum logic {
        st_idle = 1'b0,
        st_send = 1'b1
    } sched_state_e;

endpackage
